// ==== pecPkg.sv ====
package pecPkg;

    // ========================================
    // Widths and lengths
    // ========================================

    // Signed activation and weight width
    localparam int DataWidth  = 8;
    // Activations carried by one row beat
    localparam int ActLen     = 8;
    // Kernel side length
    localparam int KernelSize = 3;
    // Valid convolution outputs per row
    localparam int OutLen     = ActLen - KernelSize + 1;
    // Accumulator width for partial sums
    localparam int PsumWidth  = 24;

    // ========================================
    // Element and row types
    // ========================================

    // Named signed types keep array elements signed on selection
    typedef logic signed [DataWidth-1:0] dataT;
    typedef logic signed [PsumWidth-1:0] psumT;

    // One activation row, 64 bits
    typedef dataT [ActLen-1:0] actRowT;
    // One kernel row, 24 bits
    typedef dataT [KernelSize-1:0] kernelRowT;
    // One output row of partial sums, 144 bits
    typedef psumT [OutLen-1:0] psumRowT;

    // Full 3x3 kernel, 72 bits
    typedef struct packed {
        kernelRowT row0;
        kernelRowT row1;
        kernelRowT row2;
    } weightT;

    // Activation beat passed from cluster to cluster, 68 bits
    typedef struct packed {
        actRowT act;
        logic   frtRow;   // first row of a block
        logic   lstRow;   // last row of a block
        logic   lstBlk;   // last block before new weights
        logic   valPsum;  // add stored partial sum
    } actBeatT;

endpackage

// ==== pecControl.sv ====
`timescale 1ns/1ps

module pecControl (
    input  logic             clk,
    input  logic             rst_n,
    // Weight port
    input  logic             rdyWei,
    output logic             getWei,
    input  pecPkg::weightT   weights,
    // Upstream activation port
    input  logic             lstRdyAct,
    output logic             lstGetAct,
    input  pecPkg::actBeatT  lstAct,
    // Downstream activation port
    output logic             nxtRdyAct,
    input  logic             nxtGetAct,
    output pecPkg::actBeatT  nxtAct,
    // Towards the row stages and the RAM port
    output pecPkg::weightT   kernel,
    output logic             rowStart,
    output pecPkg::actBeatT  curBeat
);

    import pecPkg::*;

    // ========================================
    // Hand-off state machine
    // ========================================

    // One bit flips per step except waitGet back to cfgWei
    typedef enum logic [1:0] {
        idle    = 2'b00,
        cfgWei  = 2'b01,
        cfgAct  = 2'b11,
        waitGet = 2'b10
    } stateT;

    stateT   state;
    stateT   nextState;

    // Beat taken from upstream and held until the next cluster takes it
    actBeatT heldBeat;

    always_comb begin
        nextState = state;
        case (state)
            // Single cycle after reset
            idle: begin
                nextState = cfgWei;
            end
            // Wait for a kernel to be offered
            cfgWei: begin
                if (rdyWei) begin
                    nextState = cfgAct;
                end
            end
            // Wait for an activation row from upstream
            cfgAct: begin
                if (lstRdyAct) begin
                    nextState = waitGet;
                end
            end
            // Row on offer downstream
            waitGet: begin
                if (nxtGetAct) begin
                    // Last block goes back for new weights
                    if (heldBeat.lstBlk) begin
                        nextState = cfgWei;
                    end else begin
                        nextState = cfgAct;
                    end
                end
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    // ========================================
    // Handshake outputs
    // ========================================

    // One-cycle get pulses in the same cycle as the ready
    assign getWei    = (state == cfgWei) && rdyWei;
    assign lstGetAct = (state == cfgAct) && lstRdyAct;

    // Downstream ready is a level while the beat is held
    assign nxtRdyAct = (state == waitGet);

    // ========================================
    // Weight and activation registers
    // ========================================

    // Kernel captured on the get edge
    always_ff @(posedge clk) begin
        if (getWei) begin
            kernel <= weights;
        end
    end

    // Row and flags captured together on the get edge
    always_ff @(posedge clk) begin
        if (lstGetAct) begin
            heldBeat <= lstAct;
        end
    end

    // Start pulse one cycle after each capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rowStart <= 1'b0;
        end else begin
            rowStart <= lstGetAct;
        end
    end

    // Held beat feeds the stages and is forwarded unchanged
    assign curBeat = heldBeat;
    assign nxtAct  = heldBeat;

endmodule

// ==== convRow.sv ====
`timescale 1ns/1ps

module convRow (
    input  logic               clk,
    input  logic               rst_n,
    // Start pulse for the current row
    input  logic               rowStart,
    // Kernel row used by this stage
    input  pecPkg::kernelRowT  weightRow,
    // Activation row shared by all stages
    input  pecPkg::actRowT     actRow,
    // Partial sum from the stage before, or from the RAM
    input  pecPkg::psumRowT    psumIn,
    output pecPkg::psumRowT    psumOut
);

    import pecPkg::*;

    // ========================================
    // Three-tap multiply-accumulate
    // ========================================

    // Next value of the output register
    psumRowT dotRow;

    always_comb begin
        for (int i = 0; i < OutLen; i++) begin
            // Start from the incoming partial sum
            dotRow[i] = psumIn[i];
            // Sliding window across the row
            for (int k = 0; k < KernelSize; k++) begin
                // Sign-extend both operands before the product
                dotRow[i] = dotRow[i]
                          + psumT'(weightRow[k]) * psumT'(actRow[i + k]);
            end
        end
    end

    // ========================================
    // Output register
    // ========================================

    // Updates once per row, holds between starts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psumOut <= '0;
        end else if (rowStart) begin
            psumOut <= dotRow;
        end
    end

endmodule

// ==== psumPort.sv ====
`timescale 1ns/1ps

module psumPort #(
    parameter int PsumDepth = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // Row start and flags of the current beat
    input  logic                          rowStart,
    input  logic                          frtRow,
    input  logic                          valPsum,
    // RAM read side, data returns in the same cycle
    output logic                          enRd,
    output logic [$clog2(PsumDepth)-1:0]  addrRd,
    input  pecPkg::psumRowT               datRd,
    // RAM write side
    output logic                          enWr,
    output logic [$clog2(PsumDepth)-1:0]  addrWr,
    output pecPkg::psumRowT               datWr,
    // Final stage output and stage 0 partial-sum input
    input  pecPkg::psumRowT               finalPsum,
    output pecPkg::psumRowT               headPsum
);

    localparam int AddrWidth = $clog2(PsumDepth);

    // ========================================
    // Row index within a block
    // ========================================

    // Index of the next row to arrive
    logic [AddrWidth-1:0] rowCnt;
    // Index of the row being started
    logic [AddrWidth-1:0] curIdx;

    // First row of a block restarts at zero
    assign curIdx = frtRow ? '0 : rowCnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rowCnt <= '0;
        end else if (rowStart) begin
            rowCnt <= curIdx + AddrWidth'(1);
        end
    end

    // ========================================
    // Partial-sum read
    // ========================================

    // Read the stored sum of this output row
    assign enRd   = rowStart && valPsum;
    assign addrRd = curIdx;

    // Zero when no stored sum is to be added
    assign headPsum = enRd ? datRd : '0;

    // ========================================
    // Partial-sum write
    // ========================================

    // Row index two behind the current row is complete
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enWr   <= 1'b0;
            addrWr <= '0;
        end else begin
            // Rows 0 and 1 only fill the pipeline
            enWr <= rowStart && (curIdx >= AddrWidth'(2));
            if (rowStart) begin
                addrWr <= curIdx - AddrWidth'(2);
            end
        end
    end

    // Last stage registers on the same edge the write is armed
    assign datWr = finalPsum;

endmodule

// ==== pecCluster.sv ====
`timescale 1ns/1ps

module pecCluster #(
    parameter int PsumDepth = 16
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // Weight port
    input  logic                          rdyWei,
    output logic                          getWei,
    input  pecPkg::weightT                weights,
    // Upstream activation port
    input  logic                          lstRdyAct,
    output logic                          lstGetAct,
    input  pecPkg::actBeatT               lstAct,
    // Downstream activation port
    output logic                          nxtRdyAct,
    input  logic                          nxtGetAct,
    output pecPkg::actBeatT               nxtAct,
    // Partial-sum RAM port
    output logic                          enRd,
    output logic [$clog2(PsumDepth)-1:0]  addrRd,
    input  pecPkg::psumRowT               datRd,
    output logic                          enWr,
    output logic [$clog2(PsumDepth)-1:0]  addrWr,
    output pecPkg::psumRowT               datWr
);

    import pecPkg::*;

    // ========================================
    // Internal wiring
    // ========================================

    weightT  kernel;
    logic    rowStart;
    actBeatT curBeat;

    // Partial sums along the stage chain
    psumRowT headPsum;
    psumRowT psum0;
    psumRowT psum1;
    psumRowT psum2;

    // Handshakes, weights and the held beat
    pecControl uControl (
        .clk       (clk),
        .rst_n     (rst_n),
        .rdyWei    (rdyWei),
        .weights   (weights),
        .lstRdyAct (lstRdyAct),
        .lstAct    (lstAct),
        .nxtGetAct (nxtGetAct),
        .getWei    (getWei),
        .lstGetAct (lstGetAct),
        .nxtRdyAct (nxtRdyAct),
        .nxtAct    (nxtAct),
        .kernel    (kernel),
        .rowStart  (rowStart),
        .curBeat   (curBeat)
    );

    // ========================================
    // Kernel-row stages
    // ========================================

    // Stage 0 opens output row j with kernel row0
    convRow uRow0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .rowStart  (rowStart),
        .weightRow (kernel.row0),
        .actRow    (curBeat.act),
        .psumIn    (headPsum),
        .psumOut   (psum0)
    );

    // Stage 1 adds row1 taps one row later
    convRow uRow1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .rowStart  (rowStart),
        .weightRow (kernel.row1),
        .actRow    (curBeat.act),
        .psumIn    (psum0),
        .psumOut   (psum1)
    );

    // Stage 2 completes the output row
    convRow uRow2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .rowStart  (rowStart),
        .weightRow (kernel.row2),
        .actRow    (curBeat.act),
        .psumIn    (psum1),
        .psumOut   (psum2)
    );

    // RAM read, write and row addressing
    psumPort #(
        .PsumDepth (PsumDepth)
    ) uPsumPort (
        .clk       (clk),
        .rst_n     (rst_n),
        .rowStart  (rowStart),
        .frtRow    (curBeat.frtRow),
        .valPsum   (curBeat.valPsum),
        .enRd      (enRd),
        .addrRd    (addrRd),
        .datRd     (datRd),
        .enWr      (enWr),
        .addrWr    (addrWr),
        .datWr     (datWr),
        .finalPsum (psum2),
        .headPsum  (headPsum)
    );

endmodule

// ==== pecCluster_asserts.sv ====
`timescale 1ns/1ps

module pecCluster_asserts (
    input logic clk,
    input logic rst_n,
    input logic getWei,
    input logic lstGetAct,
    input logic nxtRdyAct,
    input logic enWr
);

    // ========================================
    // Handshake properties
    // ========================================

    // Weight and row gets come from different states
    assert property (@(posedge clk) disable iff (!rst_n) !(getWei && lstGetAct))
        else $error("getWei and lstGetAct high in the same cycle");

    // Upstream only taken once the held row is gone
    assert property (@(posedge clk) disable iff (!rst_n) lstGetAct |-> !nxtRdyAct)
        else $error("lstGetAct while nxtRdyAct is high");

    // Every write closes a row taken two cycles before
    assert property (@(posedge clk) disable iff (!rst_n) enWr |-> $past(lstGetAct, 2))
        else $error("enWr without lstGetAct two cycles earlier");

endmodule

// ==== tbPecCluster.sv ====
`timescale 1ns/1ps

module tbPecCluster;

    import pecPkg::*;

    localparam int PsumDepth   = 16;
    localparam int AddrWidth   = $clog2(PsumDepth);
    localparam int ClkPeriod   = 8;
    localparam int ResetCycles = 5;
    localparam int BlockRows   = 5;
    localparam int WaitLimit   = 20;
    localparam int StallCycles = 6;
    // Bound covers reset, two kernel loads, the preload and five blocks
    localparam int RunCycles   = ResetCycles + 2 * (WaitLimit + 8) + 2 * PsumDepth
                               + 5 * (BlockRows * (WaitLimit + 2) + StallCycles * 2 + 8);

    logic    clk;
    logic    rst_n;
    logic    rdyWei, getWei, lstRdyAct, lstGetAct, nxtRdyAct, nxtGetAct;
    weightT  weights;
    actBeatT lstAct;
    actBeatT nxtAct;
    logic    enRd, enWr;
    logic    [AddrWidth-1:0] addrRd, addrWr;
    psumRowT datRd, datWr;

    // RAM model and its preload port
    psumRowT ramMem [PsumDepth];
    psumRowT preload [PsumDepth];
    logic    loadEn;
    logic    [AddrWidth-1:0] loadAddr;

    // Observed RAM traffic
    logic    [AddrWidth-1:0] wrAddrQ [$];
    psumRowT wrDataQ [$];
    logic    [AddrWidth-1:0] rdAddrQ [$];
    int      getWeiCnt = 0;
    int      errCount = 0;
    int      checkCount = 0;
    weightT  curKernel;

    pecCluster #(.PsumDepth(PsumDepth)) UUT (.*);

    bind pecCluster pecCluster_asserts uAsserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .getWei    (getWei),
        .lstGetAct (lstGetAct),
        .nxtRdyAct (nxtRdyAct),
        .enWr      (enWr)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // ========================================
    // RAM model with async read and clocked write
    // ========================================

    assign datRd = ramMem[addrRd];

    always @(posedge clk) begin
        if (loadEn) begin
            ramMem[loadAddr] <= preload[loadAddr];
        end else if (enWr) begin
            ramMem[addrWr] <= datWr;
            wrAddrQ.push_back(addrWr);
            wrDataQ.push_back(datWr);
        end
        if (enRd) begin
            rdAddrQ.push_back(addrRd);
        end
        if (getWei) begin
            getWeiCnt++;
        end
    end

    task automatic compareValue(input string name, input logic [143:0] got,
                                input logic [143:0] expected);
        checkCount++;
        assert (got === expected) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
            errCount++;
        end
    endtask

    // Bounded wait for a rising edge with lstGetAct
    task automatic waitCapture();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!lstGetAct && cycles < WaitLimit);
        checkCount++;
        assert (lstGetAct) else begin
            $display("Upstream row not taken within %0d cycles at %0t", WaitLimit, $time);
            errCount++;
        end
    endtask

    // rdyWei held past the get so that a second pulse would be counted
    task automatic loadKernel(input weightT w);
        int startCnt;
        int cycles;
        startCnt = getWeiCnt;
        cycles = 0;
        @(negedge clk);
        weights = w;
        rdyWei = 1'b1;
        do begin
            @(posedge clk);
            cycles++;
        end while (!getWei && cycles < WaitLimit);
        checkCount++;
        assert (getWei) else begin
            $display("Weights not requested within %0d cycles at %0t", WaitLimit, $time);
            errCount++;
        end
        repeat (4) @(negedge clk);
        rdyWei = 1'b0;
        curKernel = w;
        compareValue("getWei pulses", 144'(getWeiCnt - startCnt), 144'd1);
    endtask

    // ========================================
    // One block of rows with an optional stall
    // ========================================

    task automatic runBlock(input bit usePsum, input bit lastBlk, input int stallRow);
        actBeatT   beats [BlockRows];
        kernelRowT wRows [KernelSize];
        psumRowT   expRow;
        int        wrBase;
        int        rdBase;
        int        acc;
        wrBase = wrAddrQ.size();
        rdBase = rdAddrQ.size();
        wRows = '{curKernel.row0, curKernel.row1, curKernel.row2};
        for (int r = 0; r < BlockRows; r++) begin
            for (int i = 0; i < ActLen; i++) begin
                beats[r].act[i] = dataT'($urandom_range(255, 0));
            end
            beats[r].frtRow  = (r == 0);
            beats[r].lstRow  = (r == BlockRows - 1);
            beats[r].lstBlk  = lastBlk && (r == BlockRows - 1);
            beats[r].valPsum = usePsum;
        end
        @(negedge clk);
        nxtGetAct = 1'b1;
        lstAct = beats[0];
        lstRdyAct = 1'b1;
        for (int r = 0; r < BlockRows; r++) begin
            waitCapture();
            @(negedge clk);
            // Row forwarded one cycle after capture
            compareValue("nxtRdyAct", 144'(nxtRdyAct), 144'd1);
            compareValue("nxtAct", 144'(nxtAct), 144'(beats[r]));
            if (r < BlockRows - 1) begin
                lstAct = beats[r + 1];
            end else begin
                lstRdyAct = 1'b0;
            end
            if (r == stallRow) begin
                // Downstream stalls and upstream must wait
                nxtGetAct = 1'b0;
                repeat (StallCycles) begin
                    @(posedge clk);
                    compareValue("lstGetAct", 144'(lstGetAct), 144'd0);
                    @(negedge clk);
                    compareValue("nxtAct", 144'(nxtAct), 144'(beats[r]));
                end
                nxtGetAct = 1'b1;
            end
        end
        // Last write lands in the second cycle after the final capture
        repeat (2) @(negedge clk);
        compareValue("write count", 144'(wrAddrQ.size() - wrBase), 144'(BlockRows - 2));
        compareValue("read count", 144'(rdAddrQ.size() - rdBase),
                     usePsum ? 144'(BlockRows) : 144'd0);
        for (int r = 0; r < BlockRows && usePsum && rdBase + r < rdAddrQ.size(); r++) begin
            compareValue("addrRd", 144'(rdAddrQ[rdBase + r]), 144'(r));
        end
        // Output row o from activation rows o to o+2
        for (int o = 0; o < BlockRows - 2 && wrBase + o < wrAddrQ.size(); o++) begin
            for (int i = 0; i < OutLen; i++) begin
                acc = usePsum ? int'(preload[o][i]) : 0;
                for (int r = 0; r < KernelSize; r++) begin
                    for (int k = 0; k < KernelSize; k++) begin
                        acc += int'(wRows[r][k]) * int'(beats[o + r].act[i + k]);
                    end
                end
                expRow[i] = psumT'(acc);
            end
            compareValue("addrWr", 144'(wrAddrQ[wrBase + o]), 144'(o));
            compareValue("datWr", 144'(wrDataQ[wrBase + o]), 144'(expRow));
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        weightT kernelA;
        weightT kernelB;
        void'($urandom(32'hc393));
        rst_n = 1'b0;
        // Both readies stay high through reset so the gets are exercised
        rdyWei = 1'b1;
        lstRdyAct = 1'b1;
        nxtGetAct = 1'b0;
        weights = '0;
        lstAct = '0;
        loadEn = 1'b0;
        loadAddr = '0;
        kernelA = 72'({$urandom, $urandom, $urandom});
        kernelB = 72'({$urandom, $urandom, $urandom});
        repeat (ResetCycles) @(negedge clk);
        // Test 1 checks quiet control outputs then one weight load
        compareValue("getWei lstGetAct nxtRdyAct enRd enWr",
                     144'({getWei, lstGetAct, nxtRdyAct, enRd, enWr}), 144'd0);
        rdyWei = 1'b0;
        lstRdyAct = 1'b0;
        rst_n = 1'b1;
        loadKernel(kernelA);
        // Test 2 runs a plain block
        runBlock(1'b0, 1'b0, -1);
        // Test 3 adds stored sums
        for (int a = 0; a < PsumDepth; a++) begin
            for (int i = 0; i < OutLen; i++) begin
                preload[a][i] = psumT'(int'($urandom_range(200000, 0)) - 100000);
            end
        end
        @(negedge clk);
        loadEn = 1'b1;
        for (int a = 0; a < PsumDepth; a++) begin
            loadAddr = AddrWidth'(a);
            @(negedge clk);
        end
        loadEn = 1'b0;
        runBlock(1'b1, 1'b0, -1);
        // Test 4 applies back-pressure on row 1
        runBlock(1'b0, 1'b0, 1);
        // Test 5 sends the cluster back to weights after the last block
        runBlock(1'b0, 1'b1, -1);
        @(negedge clk);
        lstRdyAct = 1'b1;
        repeat (4) begin
            @(posedge clk);
            compareValue("lstGetAct", 144'(lstGetAct), 144'd0);
        end
        @(negedge clk);
        lstRdyAct = 1'b0;
        loadKernel(kernelB);
        runBlock(1'b0, 1'b0, -1);
        $display("Summary: %0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the test lengths
    initial begin
        #(RunCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles, run stopped", RunCycles);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== pecCluster.f ====
pecPkg.sv
pecControl.sv
convRow.sv
psumPort.sv
pecCluster.sv
pecCluster_asserts.sv
tbPecCluster.sv

// ==== Makefile ====
TOP := tbPecCluster

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and look for the pass message in sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f pecCluster.f
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "Test completed successfully" sim.log || \
		(echo "make test: pass message not found in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
